// ==== logic/mpf_edge_config.svh ====
// Size settings for the FIU write edge, included by the package and any module that sizes storage
`ifndef MPF_EDGE_CONFIG_SVH
`define MPF_EDGE_CONFIG_SVH

// ==========================================================================
// Write heap geometry
// ==========================================================================

// Packet slots in the write heap, one slot per write packet
`define MPF_WR_HEAP_ENTRIES 8

// Largest write packet in cache-line beats
`define MPF_MAX_BEATS 4

// ==========================================================================
// Request channel widths and buffering
// ==========================================================================

`define MPF_DATA_WIDTH 64
`define MPF_ADDR_WIDTH 32

// Header FIFO between decode and execute
`define MPF_TX_FIFO_DEPTH 8
// Almost-full rises at this occupancy, leaving room for in-flight beats
`define MPF_TX_ALM_FULL_THRESHOLD 4

`endif

// ==== logic/mpf_edge_pkg.sv ====
// Shared types of the FIU write edge; import it wherever these structs and enums are used
`include "mpf_edge_config.svh"

package mpf_edge_pkg;

    // ======================================================================
    // Scalar types
    // ======================================================================

    // Cache-line address and one beat of line data
    typedef logic [`MPF_ADDR_WIDTH-1:0] t_cl_addr;
    typedef logic [`MPF_DATA_WIDTH-1:0] t_cl_data;

    // Beat number within a packet, also used for a length minus one
    typedef logic [$clog2(`MPF_MAX_BEATS)-1:0] t_cl_num;

    // One heap slot holds a whole packet
    typedef logic [$clog2(`MPF_WR_HEAP_ENTRIES)-1:0] t_heap_idx;

    // RAM word address is the slot followed by the beat number
    typedef logic [$bits(t_heap_idx)+$bits(t_cl_num)-1:0] t_heap_addr;

    typedef enum logic {
        REQ_READ,
        REQ_WRITE
    } t_req_kind;

    // Execute stage 1 either waits for a header or walks the beats of one
    typedef enum logic {
        EXP_IDLE,
        EXP_BEATS
    } t_expand_state;

    // ======================================================================
    // Packed structs
    // ======================================================================

    // Request header, the mdata tag is carried through untouched
    typedef struct packed {
        t_req_kind  kind;
        t_cl_addr   address;
        t_cl_num    cl_len;
        logic       sop;
        logic [7:0] mdata;
    } t_tx_hdr;

    typedef struct packed {
        logic     valid;
        t_tx_hdr  hdr;
        t_cl_data data;
    } t_afu_beat;

    // Header FIFO entry, the slot tells execute where the data waits
    typedef struct packed {
        t_tx_hdr   hdr;
        t_heap_idx heap_idx;
    } t_fifo_req;

    typedef struct packed {
        logic     valid;
        t_tx_hdr  hdr;
        t_cl_data data;
    } t_fiu_tx;

    typedef struct packed {
        logic       en;
        t_heap_addr addr;
        t_cl_data   data;
    } t_heap_wr;

    typedef struct packed {
        logic      en;
        t_heap_idx idx;
    } t_heap_free;

endpackage

// ==== logic/write_heap_ram.sv ====
// Write heap data store, one write port from decode and a two-cycle read port for execute
`timescale 1ns/1ps
`include "mpf_edge_config.svh"

module write_heap_ram
(
    input  logic                     clk,

    // Beat data from the decode stage
    input  mpf_edge_pkg::t_heap_wr   wr,

    // Read port, data follows the address by two cycles
    input  mpf_edge_pkg::t_heap_addr raddr,
    output mpf_edge_pkg::t_cl_data   rdata
);

    import mpf_edge_pkg::*;

    // Every slot owns MPF_MAX_BEATS consecutive words
    localparam int N_WORDS = `MPF_WR_HEAP_ENTRIES * `MPF_MAX_BEATS;

    t_cl_data mem [0:N_WORDS-1];

    // Registered read, the first of the two read cycles
    t_cl_data rd_q;

    // ======================================================================
    // Write port
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ======================================================================
    // Read port with one extra output stage
    // ======================================================================

    // A read and write to one word in the same cycle return the old word.
    // Decode always finishes writing a packet before execute can see it
    always_ff @(posedge clk)
    begin
        rd_q  <= mem[raddr];
        // Output register, lines rdata up with execute stage 3
        rdata <= rd_q;
    end

endmodule

// ==== logic/tx_req_fifo.sv ====
// Header FIFO between decode and execute; distributed-RAM storage with an occupancy threshold
`timescale 1ns/1ps

module tx_req_fifo
#(
    parameter int DEPTH     = 8,
    parameter int THRESHOLD = 4
)
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    enq_en,
    input  mpf_edge_pkg::t_fifo_req enq_data,
    output logic                    almost_full,

    output mpf_edge_pkg::t_fifo_req first,
    output logic                    not_empty,
    input  logic                    deq_en
);

    import mpf_edge_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    t_fifo_req mem [0:DEPTH-1];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head entry is read without a clock, like a LUTRAM
    assign first       = mem[rd_ptr];
    assign not_empty   = (count != '0);
    assign almost_full = (count >= CNT_W'(THRESHOLD));

    // Storage carries no reset, only the pointers do
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                // Wrap explicitly so that any depth works
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end

            if (deq_en)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous enqueue and dequeue leave the count alone
            if (enq_en && !deq_en)
            begin
                count <= count + 1'b1;
            end
            else if (deq_en && !enq_en)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Decode honours almost_full, so the last slots are never reached
    assert property (@(posedge clk) disable iff (reset)
        enq_en |-> (count != CNT_W'(DEPTH)))
        else $error("tx_req_fifo: enqueue while full");

    assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("tx_req_fifo: dequeue while empty");

endmodule

// ==== logic/write_heap_alloc.sv ====
// Decode stage of the write edge: hands out heap slots, stores beat data and queues headers
`timescale 1ns/1ps
`include "mpf_edge_config.svh"

module write_heap_alloc
(
    input  logic                     clk,
    input  logic                     reset,

    // Accelerator request channel
    input  mpf_edge_pkg::t_afu_beat  afu_tx,
    output logic                     afu_alm_full,

    // Header FIFO back-pressure and slot release from execute
    input  logic                     fifo_alm_full,
    input  mpf_edge_pkg::t_heap_free heap_free,

    output mpf_edge_pkg::t_heap_wr   heap_wr,
    output logic                     enq_en,
    output mpf_edge_pkg::t_fifo_req  enq_data
);

    import mpf_edge_pkg::*;

    // One busy bit per packet slot
    logic [`MPF_WR_HEAP_ENTRIES-1:0] busy;
    t_heap_idx free_idx;
    logic      any_free;

    // Packet in progress, held from its first beat
    logic      in_pkt;
    t_tx_hdr   pkt_hdr;
    t_heap_idx pkt_idx;
    t_cl_num   beat_cnt;

    // Values for the beat on the input this cycle
    t_tx_hdr   cur_hdr;
    t_heap_idx cur_slot;
    t_cl_num   cur_beat;
    logic      is_write;
    logic      last_beat;
    logic      alloc;

    // Lowest free slot wins, so scan from the top down
    always_comb
    begin
        free_idx = '0;
        for (int i = `MPF_WR_HEAP_ENTRIES - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_idx = t_heap_idx'(i);
            end
        end
        any_free = |(~busy);
    end

    // New packets stop while the FIFO fills up or the heap is exhausted
    assign afu_alm_full = fifo_alm_full || !any_free;

    always_comb
    begin
        // The first beat's header governs the whole packet
        cur_hdr   = in_pkt ? pkt_hdr : afu_tx.hdr;
        cur_slot  = in_pkt ? pkt_idx : free_idx;
        cur_beat  = in_pkt ? beat_cnt : '0;
        is_write  = afu_tx.valid && (cur_hdr.kind == REQ_WRITE);
        last_beat = (cur_beat == cur_hdr.cl_len);
        alloc     = is_write && !in_pkt;

        heap_wr.en   = is_write;
        heap_wr.addr = {cur_slot, cur_beat};
        heap_wr.data = afu_tx.data;

        // Reads go straight in, writes only once all data is stored
        enq_en            = afu_tx.valid && ((cur_hdr.kind == REQ_READ) || last_beat);
        enq_data.hdr      = cur_hdr;
        enq_data.heap_idx = cur_slot;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy   <= '0;
            in_pkt <= 1'b0;
        end
        else
        begin
            // A freed slot is never the one being allocated, it was busy
            if (heap_free.en)
            begin
                busy[heap_free.idx] <= 1'b0;
            end
            if (alloc)
            begin
                busy[cur_slot] <= 1'b1;
            end
            if (is_write)
            begin
                in_pkt <= !last_beat;
            end
        end
    end

    // Packet bookkeeping, only meaningful while in_pkt is set
    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            pkt_hdr <= afu_tx.hdr;
            pkt_idx <= free_idx;
        end
        if (is_write)
        begin
            beat_cnt <= t_cl_num'(cur_beat + 1'b1);
        end
    end

    // The accelerator saw afu_alm_full before starting this packet
    assert property (@(posedge clk) disable iff (reset)
        alloc |-> any_free)
        else $error("write_heap_alloc: write packet started with no free slot");

    // Execute only retires packets that decode allocated
    assert property (@(posedge clk) disable iff (reset)
        heap_free.en |-> busy[heap_free.idx])
        else $error("write_heap_alloc: freed a slot that was not busy");

endmodule

// ==== logic/write_beat_expander.sv ====
// Execute stage of the write edge: expands queued writes into beats and drives the FIU channel
`timescale 1ns/1ps

module write_beat_expander
(
    input  logic                     clk,
    input  logic                     reset,

    // Header FIFO head
    input  mpf_edge_pkg::t_fifo_req  fifo_first,
    input  logic                     fifo_not_empty,
    output logic                     fifo_deq,

    // Heap read port, data returns two cycles after the address
    output mpf_edge_pkg::t_heap_addr heap_raddr,
    input  mpf_edge_pkg::t_cl_data   heap_rdata,

    // Slot release back to decode
    output mpf_edge_pkg::t_heap_free heap_free,

    input  logic                     fiu_alm_full,
    output mpf_edge_pkg::t_fiu_tx    fiu_tx
);

    import mpf_edge_pkg::*;

    // Stage 1 holds the packet being expanded
    t_expand_state stg1_state;
    t_tx_hdr       stg1_hdr;
    t_heap_idx     stg1_heap_idx;
    t_cl_num       stg1_beat_idx;
    t_cl_num       stg1_beats_rem;

    // Stages 2 and 3 carry beat headers while the heap read completes
    logic    stg2_valid;
    t_tx_hdr stg2_hdr;
    logic    stg3_valid;
    t_tx_hdr stg3_hdr;

    logic    may_fire;
    logic    stg1_busy;
    logic    packet_done;
    logic    stg1_is_write;
    t_tx_hdr beat_hdr;

    // ======================================================================
    // Stage 1 control
    // ======================================================================

    always_comb
    begin
        may_fire      = !fiu_alm_full;
        stg1_busy     = (stg1_state == EXP_BEATS);
        stg1_is_write = (stg1_hdr.kind == REQ_WRITE);

        // Last beat of the packet leaves stage 1 this cycle
        packet_done = may_fire && stg1_busy && (stg1_beats_rem == '0);

        // Refill as the current packet finishes so packets run back to back
        fifo_deq = fifo_not_empty && (!stg1_busy || packet_done);

        // Heap word for the beat that stage 1 is issuing
        heap_raddr = {stg1_heap_idx, stg1_beat_idx};

        // Writes get per-beat sop and address, reads keep their header
        beat_hdr = stg1_hdr;
        if (stg1_is_write)
        begin
            beat_hdr.sop = (stg1_beat_idx == '0);
            beat_hdr.address[$bits(t_cl_num)-1:0] =
                stg1_hdr.address[$bits(t_cl_num)-1:0] | stg1_beat_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg1_state <= EXP_IDLE;
        end
        else if (fifo_deq)
        begin
            stg1_state <= EXP_BEATS;
        end
        else if (packet_done)
        begin
            stg1_state <= EXP_IDLE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fifo_deq)
        begin
            stg1_hdr      <= fifo_first.hdr;
            stg1_heap_idx <= fifo_first.heap_idx;
            stg1_beat_idx <= '0;
            // A read is one beat whatever its cl_len field holds
            stg1_beats_rem <= (fifo_first.hdr.kind == REQ_WRITE) ? fifo_first.hdr.cl_len : '0;
        end
        else if (may_fire && stg1_busy)
        begin
            // Middle of a multi-beat write
            stg1_beat_idx  <= t_cl_num'(stg1_beat_idx + 1'b1);
            stg1_beats_rem <= t_cl_num'(stg1_beats_rem - 1'b1);
        end
    end

    // ======================================================================
    // Stages 2 and 3
    // ======================================================================

    // FIU back-pressure inserts bubbles at stage 2, stage 3 always moves
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stg2_valid <= 1'b0;
            stg3_valid <= 1'b0;
            heap_free.en <= 1'b0;
        end
        else
        begin
            stg2_valid   <= may_fire && stg1_busy;
            stg3_valid   <= stg2_valid;
            // Slot goes back to decode the cycle after its last beat is read
            heap_free.en <= packet_done && stg1_is_write;
        end
    end

    always_ff @(posedge clk)
    begin
        stg2_hdr      <= beat_hdr;
        stg3_hdr      <= stg2_hdr;
        heap_free.idx <= stg1_heap_idx;
    end

    // Heap data lands in step with stage 3, reads carry don't-care data
    assign fiu_tx.valid = stg3_valid;
    assign fiu_tx.hdr   = stg3_hdr;
    assign fiu_tx.data  = heap_rdata;

    // Two stages drain after back-pressure, then the channel goes quiet
    assert property (@(posedge clk) disable iff (reset)
        fiu_alm_full [*3] |-> !fiu_tx.valid)
        else $error("write_beat_expander: beat sent under sustained back-pressure");

endmodule

// ==== logic/mpf_write_edge.sv ====
// Top of the FIU write edge: decode, header FIFO, write heap and execute between accelerator and FIU
`timescale 1ns/1ps
`include "mpf_edge_config.svh"

module mpf_write_edge
(
    input  logic                    clk,
    input  logic                    reset,

    // Accelerator side
    input  mpf_edge_pkg::t_afu_beat afu_tx,
    output logic                    afu_alm_full,

    // FIU side
    output mpf_edge_pkg::t_fiu_tx   fiu_tx,
    input  logic                    fiu_alm_full
);

    import mpf_edge_pkg::*;

    t_heap_wr   heap_wr;
    t_heap_addr heap_raddr;
    t_cl_data   heap_rdata;
    t_heap_free heap_free;

    logic       enq_en;
    t_fifo_req  enq_data;
    logic       fifo_alm_full;
    t_fifo_req  fifo_first;
    logic       fifo_not_empty;
    logic       fifo_deq;

    // ======================================================================
    // Decode, buffering, storage and execute
    // ======================================================================

    write_heap_alloc decode (
        .clk, .reset,
        .afu_tx, .afu_alm_full,
        .fifo_alm_full, .heap_free,
        .heap_wr, .enq_en, .enq_data
    );

    tx_req_fifo #(
        .DEPTH(`MPF_TX_FIFO_DEPTH),
        .THRESHOLD(`MPF_TX_ALM_FULL_THRESHOLD)
    ) req_fifo (
        .clk, .reset,
        .enq_en, .enq_data, .almost_full(fifo_alm_full),
        .first(fifo_first), .not_empty(fifo_not_empty), .deq_en(fifo_deq)
    );

    write_heap_ram heap (
        .clk,
        .wr(heap_wr), .raddr(heap_raddr), .rdata(heap_rdata)
    );

    write_beat_expander execute (
        .clk, .reset,
        .fifo_first, .fifo_not_empty, .fifo_deq,
        .heap_raddr, .heap_rdata, .heap_free,
        .fiu_alm_full, .fiu_tx
    );

endmodule

// ==== tb/tb_mpf_write_edge.sv ====
// Self-checking testbench for the FIU write edge; run it as the top module with the file list
`timescale 1ns/1ps
`include "mpf_edge_config.svh"

module tb_mpf_write_edge;

    import mpf_edge_pkg::*;

    // All data beats of one packet, beat i in element i
    typedef t_cl_data [`MPF_MAX_BEATS-1:0] t_pkt_data;

    // Request mixes that the stimulus can ask for
    localparam int MODE_SINGLE = 0;
    localparam int MODE_MULTI  = 1;
    localparam int MODE_MIXED  = 2;
    localparam int MODE_WRITE  = 3;

    // How fiu_alm_full is driven on each cycle
    localparam int FIU_LOW    = 0;
    localparam int FIU_HOLD   = 1;
    localparam int FIU_RANDOM = 2;

    // About 96 requests of at most four beats, four cycles a beat, with room for stalls
    localparam int MAX_CYCLES = 4000;

    // A full FIFO plus stage 1 holds well under 30 beats, which drain one a cycle
    localparam int DRAIN_CYCLES = 200;

    logic      clk;
    logic      reset;
    t_afu_beat afu_tx;
    logic      afu_alm_full;
    t_fiu_tx   fiu_tx;
    logic      fiu_alm_full;

    logic [31:0] lfsr;
    int          fiu_mode;
    int          cycle_count;
    t_fiu_tx     exp_q [$];

    mpf_write_edge dut0 (
        .clk,
        .reset,
        .afu_tx,
        .afu_alm_full,
        .fiu_tx,
        .fiu_alm_full
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ======================================================================
    // Failure reporting and the value check
    // ======================================================================

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic report_error(input string why);
        $display("ERROR at %0t: %s", $time, why);
        stop_failed();
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
            stop_failed();
        end
    endtask

    // ======================================================================
    // Random numbers
    // ======================================================================

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================

    function automatic int beats_of(input t_tx_hdr hdr);
        return (hdr.kind == REQ_WRITE) ? int'(hdr.cl_len) + 1 : 1;
    endfunction

    // A write becomes one FIU beat per line, a read passes through as is
    function automatic void expect_request(input t_tx_hdr hdr, input t_pkt_data data);
        t_fiu_tx beat;
        for (int i = 0; i < beats_of(hdr); i++)
        begin
            beat.valid = 1'b1;
            beat.hdr   = hdr;
            beat.data  = data[i];
            if (hdr.kind == REQ_WRITE)
            begin
                beat.hdr.sop     = (i == 0);
                beat.hdr.address = hdr.address | t_cl_addr'(i);
            end
            exp_q.push_back(beat);
        end
    endfunction

    // ======================================================================
    // Stimulus
    // ======================================================================

    // Advance to just after the next rising edge and set this cycle's FIU level
    task automatic next_cycle();
        logic [63:0] r;
        @(posedge clk);
        #1;
        if (fiu_mode == FIU_RANDOM)
        begin
            r = rand_bits(2);
            fiu_alm_full = (r[1:0] == 2'b00);
        end
        else
        begin
            fiu_alm_full = (fiu_mode == FIU_HOLD);
        end
    endtask

    task automatic build_request(input int mode, output t_tx_hdr hdr, output t_pkt_data data);
        logic [63:0] r;
        hdr  = '0;
        data = '0;
        r = rand_bits(1);
        if (mode == MODE_MIXED && r[0])
        begin
            hdr.kind = REQ_READ;
        end
        else
        begin
            hdr.kind = REQ_WRITE;
        end
        r = rand_bits(2);
        if (mode == MODE_SINGLE)
        begin
            hdr.cl_len = '0;
        end
        else if (mode == MODE_MULTI)
        begin
            // Two to four beats
            hdr.cl_len = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
        end
        else
        begin
            hdr.cl_len = r[1:0];
        end
        // Packets start on a four-line boundary
        r = rand_bits(30);
        hdr.address = {r[29:0], 2'b00};
        r = rand_bits(8);
        hdr.mdata = r[7:0];
        hdr.sop   = 1'b1;
        for (int i = 0; i < beats_of(hdr); i++)
        begin
            if (hdr.kind == REQ_WRITE)
            begin
                data[i] = rand_bits(64);
            end
        end
    endtask

    // Stall while the edge asks the accelerator not to start a packet
    task automatic wait_accepting();
        while (afu_alm_full)
        begin
            next_cycle();
        end
    endtask

    task automatic send_request(input t_tx_hdr hdr, input t_pkt_data data);
        expect_request(hdr, data);
        for (int i = 0; i < beats_of(hdr); i++)
        begin
            afu_tx.valid = 1'b1;
            afu_tx.hdr   = hdr;
            afu_tx.data  = data[i];
            next_cycle();
        end
        afu_tx.valid = 1'b0;
    endtask

    task automatic run_requests(input int mode, input int count);
        t_tx_hdr   hdr;
        t_pkt_data data;
        for (int n = 0; n < count; n++)
        begin
            wait_accepting();
            build_request(mode, hdr, data);
            send_request(hdr, data);
        end
    endtask

    // Give the pipeline a bounded number of cycles to empty the scoreboard
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES)
        begin
            next_cycle();
            waited++;
        end
    endtask

    // ======================================================================
    // Output comparison and run limit
    // ======================================================================

    // Falling edge sampling keeps clear of the registered outputs changing
    always @(negedge clk)
    begin
        t_fiu_tx exp_beat;
        if (!reset && fiu_tx.valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                report_error("the FIU received a beat that no request accounts for");
            end
            else
            begin
                exp_beat = exp_q.pop_front();
                check_value("fiu_tx.hdr.kind", 64'(fiu_tx.hdr.kind), 64'(exp_beat.hdr.kind));
                check_value("fiu_tx.hdr.address", 64'(fiu_tx.hdr.address),
                            64'(exp_beat.hdr.address));
                check_value("fiu_tx.hdr.cl_len", 64'(fiu_tx.hdr.cl_len),
                            64'(exp_beat.hdr.cl_len));
                check_value("fiu_tx.hdr.sop", 64'(fiu_tx.hdr.sop), 64'(exp_beat.hdr.sop));
                check_value("fiu_tx.hdr.mdata", 64'(fiu_tx.hdr.mdata), 64'(exp_beat.hdr.mdata));
                // Read beats carry no data
                if (exp_beat.hdr.kind == REQ_WRITE)
                begin
                    check_value("fiu_tx.data", fiu_tx.data, exp_beat.data);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d beats still expected",
                     cycle_count, exp_q.size());
            stop_failed();
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        t_tx_hdr   hdr;
        t_pkt_data data;
        int        accepted;
        lfsr         = 32'h8f6b;
        cycle_count  = 0;
        fiu_mode     = FIU_LOW;
        reset        = 1'b1;
        afu_tx       = '0;
        fiu_alm_full = 1'b0;
        accepted     = 0;

        next_cycle();
        next_cycle();
        reset = 1'b0;

        // Idle outputs straight after reset
        check_value("fiu_tx.valid", 64'(fiu_tx.valid), 64'd0);
        check_value("afu_alm_full", 64'(afu_alm_full), 64'd0);

        run_requests(MODE_SINGLE, 6);
        run_requests(MODE_MULTI, 12);
        run_requests(MODE_MIXED, 20);
        wait_drain();

        // Random FIU back-pressure across a mixed stream
        fiu_mode = FIU_RANDOM;
        run_requests(MODE_MIXED, 40);
        fiu_mode = FIU_LOW;
        wait_drain();

        // Hold the FIU off until the edge pushes back on the accelerator
        fiu_mode = FIU_HOLD;
        next_cycle();
        while (!afu_alm_full)
        begin
            if (accepted >= 8)
            begin
                report_error("afu_alm_full stayed low after 8 writes under FIU back-pressure");
            end
            else
            begin
                build_request(MODE_WRITE, hdr, data);
                send_request(hdr, data);
                accepted++;
            end
        end
        $display("Accelerator held off after %0d write packets", accepted);

        // More writes than there are heap slots, so freed slots must come back
        fiu_mode = FIU_LOW;
        run_requests(MODE_WRITE, 10);
        wait_drain();

        // Any stray beat in these cycles hits the empty scoreboard
        repeat (8) next_cycle();
        if (exp_q.size() == 0)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            report_error("expected beats were never delivered to the FIU");
        end
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/mpf_edge_pkg.sv
logic/write_heap_ram.sv
logic/tx_req_fifo.sv
logic/write_heap_alloc.sv
logic/write_beat_expander.sv
logic/mpf_write_edge.sv
tb/tb_mpf_write_edge.sv

// ==== Makefile ====
# Verilator build for the FIU write edge and its testbench

VERILATOR  ?= verilator
FILELIST   := filelist.f
TOP        := tb_mpf_write_edge
OBJ_DIR    := obj_dir
VFLAGS     := --timing --assert
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The testbench ends every failing run with $fatal, so the exit status carries the result
sim:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
